// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t; // Instruction, address or immediate
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        OP_NONE = 6'd0,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } op_t;

    typedef enum logic [2:0] {
        FMT_NONE = 3'd0, // Illegal or unused encoding
        FMT_U,
        FMT_J,
        FMT_B,
        FMT_S,
        FMT_R,
        FMT_I
    } fmt_t;

    // Major opcodes, low two bits included
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

endpackage

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Unit besides the ROB that takes the instruction
    typedef enum logic [1:0] {
        UNIT_ROB = 2'd0,
        UNIT_LSB,
        UNIT_RS
    } unit_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t inst;
        isa_pkg::word_t addr;
        logic           jump_pred;
    } fetch_t;

    typedef struct packed {
        logic rob;
        logic lsb;
        logic rs;
    } full_t;

    typedef struct packed {
        isa_pkg::op_t      op;
        unit_t             unit;
        logic              jump_pred;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    addr;
    } dec_pkt_t;

endpackage

`default_nettype wire

// File: logic/op_decode.sv
`timescale 1ns/100ps
`default_nettype none

module op_decode (
    input  isa_pkg::word_t    inst,
    output isa_pkg::op_t      op,
    output isa_pkg::fmt_t     fmt,
    output pipe_pkg::unit_t   unit,
    output isa_pkg::reg_idx_t rd,
    output isa_pkg::reg_idx_t rs1,
    output isa_pkg::reg_idx_t rs2
);
    logic [2:0] funct3;
    logic       alt; // Bit 30 picks SUB, SRA, SRAI

    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    always_comb begin
        op  = isa_pkg::OP_NONE;
        fmt = isa_pkg::FMT_NONE;
        case (inst[6:0])
            isa_pkg::OPC_LUI: begin
                op  = isa_pkg::OP_LUI;
                fmt = isa_pkg::FMT_U;
            end
            isa_pkg::OPC_AUIPC: begin
                op  = isa_pkg::OP_AUIPC;
                fmt = isa_pkg::FMT_U;
            end
            isa_pkg::OPC_JAL: begin
                op  = isa_pkg::OP_JAL;
                fmt = isa_pkg::FMT_J;
            end
            isa_pkg::OPC_JALR: begin
                fmt = isa_pkg::FMT_I;
                if (funct3 == 3'b000) begin
                    op = isa_pkg::OP_JALR;
                end
            end
            isa_pkg::OPC_BRANCH: begin
                fmt = isa_pkg::FMT_B;
                case (funct3)
                    3'b000:  op = isa_pkg::OP_BEQ;
                    3'b001:  op = isa_pkg::OP_BNE;
                    3'b100:  op = isa_pkg::OP_BLT;
                    3'b101:  op = isa_pkg::OP_BGE;
                    3'b110:  op = isa_pkg::OP_BLTU;
                    3'b111:  op = isa_pkg::OP_BGEU;
                    default: op = isa_pkg::OP_NONE;
                endcase
            end
            isa_pkg::OPC_LOAD: begin
                fmt = isa_pkg::FMT_I;
                case (funct3)
                    3'b000:  op = isa_pkg::OP_LB;
                    3'b001:  op = isa_pkg::OP_LH;
                    3'b010:  op = isa_pkg::OP_LW;
                    3'b100:  op = isa_pkg::OP_LBU;
                    3'b101:  op = isa_pkg::OP_LHU;
                    default: op = isa_pkg::OP_NONE;
                endcase
            end
            isa_pkg::OPC_STORE: begin
                fmt = isa_pkg::FMT_S;
                case (funct3)
                    3'b000:  op = isa_pkg::OP_SB;
                    3'b001:  op = isa_pkg::OP_SH;
                    3'b010:  op = isa_pkg::OP_SW;
                    default: op = isa_pkg::OP_NONE;
                endcase
            end
            isa_pkg::OPC_OP_IMM: begin
                fmt = isa_pkg::FMT_I;
                case (funct3)
                    3'b000: op = isa_pkg::OP_ADDI;
                    3'b001: op = isa_pkg::OP_SLLI;
                    3'b010: op = isa_pkg::OP_SLTI;
                    3'b011: op = isa_pkg::OP_SLTIU;
                    3'b100: op = isa_pkg::OP_XORI;
                    3'b101: begin
                        if (alt) begin
                            op = isa_pkg::OP_SRAI;
                        end else begin
                            op = isa_pkg::OP_SRLI;
                        end
                    end
                    3'b110: op = isa_pkg::OP_ORI;
                    3'b111: op = isa_pkg::OP_ANDI;
                endcase
            end
            isa_pkg::OPC_OP: begin
                fmt = isa_pkg::FMT_R;
                case (funct3)
                    3'b000: begin
                        if (alt) begin
                            op = isa_pkg::OP_SUB;
                        end else begin
                            op = isa_pkg::OP_ADD;
                        end
                    end
                    3'b001: op = isa_pkg::OP_SLL;
                    3'b010: op = isa_pkg::OP_SLT;
                    3'b011: op = isa_pkg::OP_SLTU;
                    3'b100: op = isa_pkg::OP_XOR;
                    3'b101: begin
                        if (alt) begin
                            op = isa_pkg::OP_SRA;
                        end else begin
                            op = isa_pkg::OP_SRL;
                        end
                    end
                    3'b110: op = isa_pkg::OP_OR;
                    3'b111: op = isa_pkg::OP_AND;
                endcase
            end
            default: ;
        endcase
        if (op == isa_pkg::OP_NONE) begin
            fmt = isa_pkg::FMT_NONE; // Reserved funct3 decodes as illegal
        end
    end

    always_comb begin
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
        case (fmt)
            isa_pkg::FMT_U, isa_pkg::FMT_J: begin
                rd = inst[11:7];
            end
            isa_pkg::FMT_B, isa_pkg::FMT_S: begin
                rs1 = inst[19:15];
                rs2 = inst[24:20];
            end
            isa_pkg::FMT_R: begin
                rd  = inst[11:7];
                rs1 = inst[19:15];
                rs2 = inst[24:20];
            end
            isa_pkg::FMT_I: begin
                rd  = inst[11:7];
                rs1 = inst[19:15];
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            isa_pkg::OP_LUI, isa_pkg::OP_AUIPC, isa_pkg::OP_JAL: begin
                unit = pipe_pkg::UNIT_ROB;
            end
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW, isa_pkg::OP_LBU,
            isa_pkg::OP_LHU, isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW: begin
                unit = pipe_pkg::UNIT_LSB;
            end
            default: unit = pipe_pkg::UNIT_RS; // Illegal ops also go to RS
        endcase
    end

endmodule

`default_nettype wire

// File: logic/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  isa_pkg::word_t inst,
    input  isa_pkg::fmt_t  fmt,
    output isa_pkg::word_t imm
);
    logic is_shift;

    // SLLI, SRLI, SRAI carry a shamt instead of a signed immediate
    assign is_shift = (inst[6:0] == isa_pkg::OPC_OP_IMM) && (inst[13:12] == 2'b01);

    always_comb begin
        case (fmt)
            isa_pkg::FMT_U: begin
                imm = {inst[31:12], 12'b0};
            end
            isa_pkg::FMT_J: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            isa_pkg::FMT_B: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            isa_pkg::FMT_S: begin
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            end
            isa_pkg::FMT_I: begin
                if (is_shift) begin
                    imm = {27'b0, inst[24:20]};
                end else begin
                    imm = {{21{inst[31]}}, inst[30:20]};
                end
            end
            default: imm = '0; // R type and illegal
        endcase
    end

endmodule

`default_nettype wire

// File: logic/decode_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module decode_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               flush,
    input  logic               fet_valid,
    input  pipe_pkg::full_t    full,
    input  pipe_pkg::dec_pkt_t next_pkt,
    output logic               dec_ready,
    output pipe_pkg::dec_pkt_t dec,
    output logic               stall
);
    logic unit_full; // Target unit of the held packet is full

    always_comb begin
        case (dec.unit)
            pipe_pkg::UNIT_LSB: unit_full = full.lsb;
            pipe_pkg::UNIT_RS:  unit_full = full.rs;
            default:            unit_full = 1'b0; // ROB only
        endcase
    end

    // Every instruction needs a ROB slot
    assign stall = dec_ready && (full.rob || unit_full);

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (rst) begin
                dec_ready <= 1'b0;
                dec       <= '0;
            end else if (flush) begin
                dec_ready <= 1'b0; // Wins over stall
            end else if (!stall) begin
                dec_ready <= fet_valid;
                if (fet_valid) begin
                    dec <= next_pkt;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/decoder_top.sv
`timescale 1ns/100ps
`default_nettype none

module decoder_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               flush,
    input  pipe_pkg::fetch_t   fet,
    input  pipe_pkg::full_t    full,
    output logic               dec_ready,
    output pipe_pkg::dec_pkt_t dec,
    output logic               stall
);
    isa_pkg::op_t       op;
    isa_pkg::fmt_t      fmt;
    pipe_pkg::unit_t    unit;
    isa_pkg::reg_idx_t  rd;
    isa_pkg::reg_idx_t  rs1;
    isa_pkg::reg_idx_t  rs2;
    isa_pkg::word_t     imm;
    pipe_pkg::dec_pkt_t next_pkt;

    op_decode u_op_decode (
        .inst (fet.inst),
        .op   (op),
        .fmt  (fmt),
        .unit (unit),
        .rd   (rd),
        .rs1  (rs1),
        .rs2  (rs2)
    );

    imm_gen u_imm_gen (
        .inst (fet.inst),
        .fmt  (fmt),
        .imm  (imm)
    );

    assign next_pkt = '{op: op, unit: unit, jump_pred: fet.jump_pred, rd: rd,
                        rs1: rs1, rs2: rs2, imm: imm, addr: fet.addr};

    decode_ctrl u_decode_ctrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .flush     (flush),
        .fet_valid (fet.valid),
        .full      (full),
        .next_pkt  (next_pkt),
        .dec_ready (dec_ready),
        .dec       (dec),
        .stall     (stall)
    );

endmodule

`default_nettype wire

// File: sim/decoder_properties.sv
`timescale 1ns/100ps
`default_nettype none

module decoder_properties (
    input logic               clk,
    input logic               rst,
    input logic               rdy,
    input logic               flush,
    input logic               dec_ready,
    input logic               stall,
    input pipe_pkg::dec_pkt_t dec
);

    // Held packet frozen across a stalled edge
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(dec))
        else $error("dec changed while stall was high");

    flush_clears: assert property (@(posedge clk) disable iff (rst)
        (flush && rdy) |=> !dec_ready)
        else $error("dec_ready still high after a flush");

    // Stall only with a valid packet
    stall_needs_ready: assert property (@(posedge clk) disable iff (rst)
        stall |-> dec_ready)
        else $error("stall high while dec_ready was low");

endmodule

`default_nettype wire

// File: sim/decoder_tb.sv
`timescale 1ns/100ps
`default_nettype none

module decoder_tb;
    logic               clk = 1'b0;
    logic               rst;
    logic               rdy;
    logic               flush;
    pipe_pkg::fetch_t   fet;
    pipe_pkg::full_t    full;
    logic               dec_ready;
    logic               stall;
    pipe_pkg::dec_pkt_t dec;
    pipe_pkg::dec_pkt_t want; // Expected packet of the current instruction
    pipe_pkg::dec_pkt_t held;
    isa_pkg::word_t     inst;
    logic [31:0]        seed = 32'd14472;

    decoder_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .flush     (flush),
        .fet       (fet),
        .full      (full),
        .dec_ready (dec_ready),
        .dec       (dec),
        .stall     (stall)
    );

    bind decoder_top decoder_properties u_props (
        .clk (clk), .rst (rst), .rdy (rdy), .flush (flush),
        .dec_ready (dec_ready), .stall (stall), .dec (dec)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check(input string name, input logic [95:0] exp, input logic [95:0] act);
        assert (exp === act)
            else stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    endtask

    // Builds inst and its expected packet
    task automatic encode(input int kind, input logic alt);
        logic [31:0]   r;
        logic [31:0]   v;
        logic [31:0]   simm;
        logic [4:0]    rd;
        logic [4:0]    rs1;
        logic [4:0]    rs2;
        isa_pkg::fmt_t ef;
        r = lcg();
        v = lcg();
        {rd, rs1, rs2} = r[31:17];
        simm = {{20{v[11]}}, v[11:0]};
        want = '0;
        want.unit = pipe_pkg::UNIT_RS;
        ef = isa_pkg::FMT_NONE;
        case (kind)
            0: begin
                inst = {v[31:12], rd, isa_pkg::OPC_LUI};
                want.op = isa_pkg::OP_LUI;
                want.unit = pipe_pkg::UNIT_ROB;
                want.imm = {v[31:12], 12'b0};
                ef = isa_pkg::FMT_U;
            end
            1: begin
                inst = {v[20], v[10:1], v[11], v[19:12], rd, isa_pkg::OPC_JAL};
                want.op = isa_pkg::OP_JAL;
                want.unit = pipe_pkg::UNIT_ROB;
                want.imm = {{11{v[20]}}, v[20:1], 1'b0};
                ef = isa_pkg::FMT_J;
            end
            2: begin
                inst = {v[12], v[10:5], rs2, rs1, 3'b001, v[4:1], v[11], isa_pkg::OPC_BRANCH};
                want.op = isa_pkg::OP_BNE;
                want.imm = {{19{v[12]}}, v[12:1], 1'b0};
                ef = isa_pkg::FMT_B;
            end
            3: begin
                inst = {v[11:5], rs2, rs1, 3'b010, v[4:0], isa_pkg::OPC_STORE};
                want.op = isa_pkg::OP_SW;
                want.unit = pipe_pkg::UNIT_LSB;
                want.imm = simm;
                ef = isa_pkg::FMT_S;
            end
            4: begin
                inst = {v[11:0], rs1, 3'b010, rd, isa_pkg::OPC_LOAD};
                want.op = isa_pkg::OP_LW;
                want.unit = pipe_pkg::UNIT_LSB;
                want.imm = simm;
                ef = isa_pkg::FMT_I;
            end
            5: begin
                inst = {1'b0, alt, 5'b0, v[4:0], rs1, 3'b101, rd, isa_pkg::OPC_OP_IMM};
                want.op = alt ? isa_pkg::OP_SRAI : isa_pkg::OP_SRLI;
                want.imm = {27'b0, v[4:0]}; // Shamt, zero extended
                ef = isa_pkg::FMT_I;
            end
            6, 7: begin
                inst = {1'b0, alt, 5'b0, rs2, rs1, (kind == 6) ? 3'b000 : 3'b101, rd,
                        isa_pkg::OPC_OP};
                want.op = (kind == 6) ? (alt ? isa_pkg::OP_SUB : isa_pkg::OP_ADD)
                                      : (alt ? isa_pkg::OP_SRA : isa_pkg::OP_SRL);
                ef = isa_pkg::FMT_R;
            end
            8: inst = {v[31:15], 3'b010, v[11:7], isa_pkg::OPC_BRANCH}; // Reserved funct3
            9: inst = {v[31:15], 3'b011, v[11:7], isa_pkg::OPC_LOAD};
            default: inst = {v[31:7], isa_pkg::OPC_OP[6:2], 2'b00}; // Not a 32-bit encoding
        endcase
        want.rd = (ef inside {isa_pkg::FMT_U, isa_pkg::FMT_J, isa_pkg::FMT_R, isa_pkg::FMT_I})
                  ? rd : 5'd0;
        want.rs1 = (ef inside {isa_pkg::FMT_B, isa_pkg::FMT_S, isa_pkg::FMT_R, isa_pkg::FMT_I})
                   ? rs1 : 5'd0;
        want.rs2 = (ef inside {isa_pkg::FMT_B, isa_pkg::FMT_S, isa_pkg::FMT_R}) ? rs2 : 5'd0;
        want.addr = lcg();
        want.jump_pred = want.addr[2];
    endtask

    task automatic present();
        @(posedge clk);
        fet <= '{valid: 1'b1, inst: inst, addr: want.addr, jump_pred: want.jump_pred};
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            n++;
            if (n > 8) stop_run("dec_ready did not rise within 8 cycles of a fetch");
        end while (!dec_ready);
        check("fetch latency", 96'(1), 96'(n));
    endtask

    task automatic apply_full(input logic rob, input logic lsb, input logic rs);
        @(posedge clk);
        full <= '{rob: rob, lsb: lsb, rs: rs};
        @(negedge clk);
    endtask

    initial begin
        rst <= 1'b1;
        rdy <= 1'b1;
        flush <= 1'b0;
        fet <= '0;
        full <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("reset dec_ready", 96'(0), 96'(dec_ready));
        check("reset stall", 96'(0), 96'(stall));
        for (int round = 0; round < 6; round++) begin
            for (int k = 0; k < 11; k++) begin
                encode(k, (round % 2) == 1);
                present();
                wait_ready();
                check($sformatf("decode kind %0d", k), 96'(want), 96'(dec));
            end
        end
        encode(4, 1'b0); // Load held in the stage
        present();
        wait_ready();
        apply_full(1'b0, 1'b0, 1'b1);
        check("load rs full", 96'(0), 96'(stall));
        apply_full(1'b0, 1'b1, 1'b0);
        check("load lsb full", 96'(1), 96'(stall));
        held = dec;
        encode(6, 1'b0);
        present();
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("stalled packet", 96'(held), 96'(dec));
        apply_full(1'b0, 1'b0, 1'b0);
        check("stall release", 96'(0), 96'(stall));
        wait_ready();
        check("add after release", 96'(want), 96'(dec));
        apply_full(1'b0, 1'b0, 1'b1);
        check("add rs full", 96'(1), 96'(stall));
        apply_full(1'b0, 1'b0, 1'b0);
        encode(0, 1'b0);
        present();
        wait_ready();
        apply_full(1'b0, 1'b1, 1'b1);
        check("lui lsb rs full", 96'(0), 96'(stall));
        apply_full(1'b1, 1'b0, 1'b0);
        check("lui rob full", 96'(1), 96'(stall));
        @(posedge clk);
        flush <= 1'b1; // Flush while stalled
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check("flush dec_ready", 96'(0), 96'(dec_ready));
        check("flush stall", 96'(0), 96'(stall));
        apply_full(1'b0, 1'b0, 1'b0);
        encode(7, 1'b1);
        present();
        wait_ready();
        held = dec;
        encode(3, 1'b0); // Store waits at the input during the pause
        @(posedge clk);
        rdy <= 1'b0;
        present();
        repeat (3) begin
            @(negedge clk);
            check("pause dec_ready", 96'(1), 96'(dec_ready));
            check("pause packet", 96'(held), 96'(dec));
        end
        @(posedge clk);
        fet.valid <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check("pause dec_ready", 96'(1), 96'(dec_ready));
            check("pause packet", 96'(held), 96'(dec));
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/op_decode.sv
logic/imm_gen.sv
logic/decode_ctrl.sv
logic/decoder_top.sv
sim/decoder_properties.sv
sim/decoder_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := decoder_tb
FILELIST := list.f

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
